// ==== testbench/golden_frame.hex ====
// 32 memory words from the frame base, eight per line, pixel 0 in bits 15:0
// then 64 expected rgb565 pixels in raster order, eight per line
81FE80FF 83FC82FD 85FA84FB 87F886F9 89F688F7 8BF48AF5 8DF28CF3 8FF08EF1
91EE90EF 93EC92ED 95EA94EB 97E896E9 99E698E7 9BE49AE5 9DE29CE3 9FE09EE1
A1DEA0DF A3DCA2DD A5DAA4DB A7D8A6D9 A9D6A8D7 ABD4AAD5 ADD2ACD3 AFD0AED1
B1CEB0CF B3CCB2CD B5CAB4CB B7C8B6C9 B9C6B8C7 BBC4BAC5 BDC2BCC3 BFC0BEC1
80FF 81FE 82FD 83FC 84FB 85FA 86F9 87F8
88F7 89F6 8AF5 8BF4 8CF3 8DF2 8EF1 8FF0
90EF 91EE 92ED 93EC 94EB 95EA 96E9 97E8
98E7 99E6 9AE5 9BE4 9CE3 9DE2 9EE1 9FE0
A0DF A1DE A2DD A3DC A4DB A5DA A6D9 A7D8
A8D7 A9D6 AAD5 ABD4 ACD3 ADD2 AED1 AFD0
B0CF B1CE B2CD B3CC B4CB B5CA B6C9 B7C8
B8C7 B9C6 BAC5 BBC4 BCC3 BDC2 BEC1 BFC0

// ==== flist.f ====
common/vga_pkg.sv
rtl/sync_fifo.sv
video_timing/video_timing.sv
video_timing/frame_restart.sv
video_fetch/video_fetch.sv
rtl/pixel_unpack.sv
rtl/pixel_out.sv
rtl/vga_top.sv
testbench/tb_vga.sv

// ==== Makefile ====
# Verilator build and run of the frame-buffer video testbench

VERILATOR ?= verilator
TOP       ?= tb_vga
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_vga.sv ====
`timescale 1ns/1ps

module tb_vga
  import vga_pkg::*;
();

  ////////////////////////////////////////////////////////////
  // bench constants
  ////////////////////////////////////////////////////////////

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] SEED         = 32'hde99_7bbf;
  localparam logic [31:0] BASE_ADDR    = FRAME_BASE_DEFAULT;
  localparam int          BURST        = 4;
  localparam int          RESTART      = 4;

  // raster on the pins is 24 by 8 in total
  localparam int H_ACTIVE     = 16;
  localparam int H_SYNC_BEG   = 18;
  localparam int H_SYNC_W     = 3;
  localparam int H_TOTAL      = 24;
  localparam int V_ACTIVE     = 4;
  localparam int V_SYNC_BEG   = 5;
  localparam int V_TOTAL      = 8;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

  localparam int FRAME_WORDS    = 32;
  localparam int FRAME_PIXELS   = 64;
  localparam int FIRST_CHECKED  = 2;
  localparam int LAST_CHECKED   = 3;
  localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + RESET_CYCLES + 100;

  logic       clk_axi;
  logic       rst_n;
  mem_rsp_t   mem_rsp;
  mem_req_t   mem_req;
  logic       hsync;
  logic       vsync;
  logic [4:0] red;
  logic [5:0] green;
  logic [4:0] blue;
  logic       underrun;

  // words 0..31, then expected pixels 32..95
  logic [31:0] golden [FRAME_WORDS + FRAME_PIXELS];

  vga_top #(
    .TIMING         (sim_timing),
    .FRAME_BASE     (BASE_ADDR),
    .BURST_WORDS    (BURST),
    .RESTART_CYCLES (RESTART),
    .WORD_DEPTH     (32),
    .PIX_DEPTH      (8)
  ) uut (
    .clk_axi  (clk_axi),
    .rst_n    (rst_n),
    .mem_rsp  (mem_rsp),
    .mem_req  (mem_req),
    .hsync    (hsync),
    .vsync    (vsync),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .underrun (underrun)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("ERR %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      abort_run("stopping at first wrong value");
    end
  endtask

  // frame image at the base and address-derived filler past its end
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - BASE_ADDR;
    if (offset < 32'(FRAME_WORDS * 4))
      return golden[offset[6:2]];
    else
      return {addr[15:0] ^ 16'h5aa5, addr[31:16]};
  endfunction

  initial
  begin
    clk_axi = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk_axi = ~clk_axi;
  end

  ////////////////////////////////////////////////////////////
  // memory bus model
  ////////////////////////////////////////////////////////////

  initial
  begin : memory_model
    int          left;
    int          delay;
    logic [31:0] addr;
    logic [31:0] expect_addr;
    logic        vs_q;

    mem_rsp = '0;
    void'($urandom(SEED));
    left        = 0;
    delay       = 0;
    addr        = '0;
    expect_addr = BASE_ADDR;
    vs_q        = 1'b0;
    forever
    begin
      @(negedge clk_axi);
      mem_rsp.rd_valid = 1'b0;
      mem_rsp.rd_data  = '0;
      // idle gap first, then one word per cycle
      if (left > 0)
      begin
        if (delay > 0)
          delay = delay - 1;
        else
        begin
          mem_rsp.rd_valid = 1'b1;
          mem_rsp.rd_data  = read_word(addr);
          addr             = addr + 32'd4;
          left             = left - 1;
        end
      end
      if (mem_req.req)
      begin
        if (left > 0)
          abort_run("memory request arrived while a burst was still outstanding");
        else
        begin
          check_value(mem_req.addr, expect_addr, "burst address");
          check_value(32'(mem_req.length), 32'(BURST), "burst length");
          addr        = mem_req.addr;
          left        = int'(mem_req.length);
          delay       = int'($urandom % 4);
          expect_addr = expect_addr + 32'(BURST * 4);
        end
      end
      // a late request in the vsync cycle still carries the old address
      if (vsync && !vs_q)
        expect_addr = BASE_ADDR;
      vs_q = vsync;
    end
  end

  ////////////////////////////////////////////////////////////
  // reset, raster tracking and pixel checks
  ////////////////////////////////////////////////////////////

  initial
  begin : run_checks
    int          cycle;
    int          h;
    int          v;
    int          frame;
    int          pix_idx;
    int          hs_rise;
    int          hs_rises;
    int          vs_rise;
    int          vs_rises;
    logic        hs_q;
    logic        vs_q;
    logic        aligned;
    logic        done;
    logic        visible;
    logic [15:0] colour;

    rst_n = 1'b0;
    for (int i = 0; i < FRAME_WORDS + FRAME_PIXELS; i++)
      golden[i] = '1;
    $readmemh("testbench/golden_frame.hex", golden);
    // pixels are 16 bits, so a filled last entry has a clear upper half
    if (golden[FRAME_WORDS + FRAME_PIXELS - 1][31:16] != 16'h0)
      abort_run("golden_frame.hex is missing or holds too few values");
    cycle    = 0;
    h        = 0;
    v        = 0;
    frame    = 0;
    pix_idx  = 0;
    hs_rise  = 0;
    hs_rises = 0;
    vs_rise  = 0;
    vs_rises = 0;
    hs_q     = 1'b0;
    vs_q     = 1'b0;
    aligned  = 1'b0;
    done     = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_axi);
    rst_n = 1'b1;
    cycle = RESET_CYCLES;

    while (!done)
    begin
      @(negedge clk_axi);
      cycle  = cycle + 1;
      colour = {red, green, blue};
      if (cycle > TIMEOUT_CYCLES)
        abort_run($sformatf("timeout, no result after %0d cycles", TIMEOUT_CYCLES));
      else
      begin
        check_value(32'(underrun), 32'd0, "underrun flag");

        // sync widths and periods from their own edges
        if (hsync && !hs_q)
        begin
          if (hs_rises > 0)
            check_value(32'(cycle - hs_rise), 32'(H_TOTAL), "hsync period");
          hs_rise  = cycle;
          hs_rises = hs_rises + 1;
        end
        else if (!hsync && hs_q)
          check_value(32'(cycle - hs_rise), 32'(H_SYNC_W), "hsync width");
        if (vsync && !vs_q)
        begin
          if (vs_rises > 0)
            check_value(32'(cycle - vs_rise), 32'(FRAME_CYCLES), "vsync period");
          vs_rise  = cycle;
          vs_rises = vs_rises + 1;
        end
        else if (!vsync && vs_q)
          check_value(32'(cycle - vs_rise), 32'(H_TOTAL), "vsync width");

        // own position counters locked to the first vsync edge
        if (aligned)
        begin
          h = h + 1;
          if (h == H_TOTAL)
          begin
            h = 0;
            v = v + 1;
            if (v == V_TOTAL)
            begin
              v       = 0;
              pix_idx = 0;
              frame   = frame + 1;
              if (frame > LAST_CHECKED)
                done = 1'b1;
            end
          end
        end
        else if (vsync && !vs_q)
        begin
          aligned = 1'b1;
          h       = 0;
          v       = V_SYNC_BEG;
          frame   = 1;
        end

        if (!aligned)
          check_value(32'(colour), 32'd0, "colour before first frame");
        else if (!done)
        begin
          check_value(32'(hsync), 32'(h >= H_SYNC_BEG && h < H_SYNC_BEG + H_SYNC_W),
                      "hsync at position");
          check_value(32'(vsync), 32'(v == V_SYNC_BEG), "vsync at position");
          visible = (h < H_ACTIVE) && (v < V_ACTIVE);
          if (!visible)
            check_value(32'(colour), 32'd0, "colour outside visible area");
          else if (frame >= FIRST_CHECKED && frame <= LAST_CHECKED)
          begin
            // low half of each word comes out first
            check_value(32'(colour), 32'(golden[FRAME_WORDS + pix_idx][15:0]),
                        $sformatf("pixel %0d of frame %0d", pix_idx, frame));
            pix_idx = pix_idx + 1;
          end
        end
        hs_q = hsync;
        vs_q = vsync;
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== rtl/vga_top.sv ====
`timescale 1ns/1ps

module vga_top
  import vga_pkg::*;
#(
  parameter timing_cfg_t TIMING         = default_timing,
  parameter logic [31:0] FRAME_BASE     = FRAME_BASE_DEFAULT,
  parameter int          BURST_WORDS    = BURST_WORDS_DEFAULT,
  parameter int          RESTART_CYCLES = RESTART_CYCLES_DEFAULT,
  parameter int          WORD_DEPTH     = 32,
  parameter int          PIX_DEPTH      = 8
)
(
  input  logic       clk_axi,
  input  logic       rst_n,
  input  mem_rsp_t   mem_rsp,
  output mem_req_t   mem_req,
  output logic       hsync,
  output logic       vsync,
  output logic [4:0] red,
  output logic [5:0] green,
  output logic [4:0] blue,
  output logic       underrun
);

  raster_t   raster;
  logic      clear;
  logic      word_pop;
  mem_word_t word_data;
  logic      word_empty;
  logic      pix_pop;
  rgb565_t   pix_data;
  logic      pix_empty;

  ////////////////////////////////////////////////////////////
  // raster and frame restart
  ////////////////////////////////////////////////////////////

  video_timing #(
    .TIMING (TIMING)
  ) u_timing (
    .clk_axi (clk_axi),
    .rst_n   (rst_n),
    .raster  (raster)
  );

  frame_restart #(
    .RESTART_CYCLES (RESTART_CYCLES)
  ) u_restart (
    .clk_axi (clk_axi),
    .rst_n   (rst_n),
    .vsync   (raster.vsync),
    .clear   (clear)
  );

  ////////////////////////////////////////////////////////////
  // fetch, unpack, output
  ////////////////////////////////////////////////////////////

  video_fetch #(
    .FRAME_BASE  (FRAME_BASE),
    .BURST_WORDS (BURST_WORDS),
    .WORD_DEPTH  (WORD_DEPTH)
  ) u_fetch (
    .clk_axi    (clk_axi),
    .rst_n      (rst_n),
    .clear      (clear),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .word_pop   (word_pop),
    .word_data  (word_data),
    .word_empty (word_empty)
  );

  pixel_unpack #(
    .PIX_DEPTH (PIX_DEPTH)
  ) u_unpack (
    .clk_axi    (clk_axi),
    .rst_n      (rst_n),
    .clear      (clear),
    .word_pop   (word_pop),
    .word_data  (word_data),
    .word_empty (word_empty),
    .pix_pop    (pix_pop),
    .pix_data   (pix_data),
    .pix_empty  (pix_empty)
  );

  pixel_out u_out (
    .clk_axi   (clk_axi),
    .rst_n     (rst_n),
    .raster    (raster),
    .pix_pop   (pix_pop),
    .pix_data  (pix_data),
    .pix_empty (pix_empty),
    .hsync     (hsync),
    .vsync     (vsync),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .underrun  (underrun)
  );

endmodule

// ==== rtl/pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out
  import vga_pkg::*;
(
  input  logic       clk_axi,
  input  logic       rst_n,
  input  raster_t    raster,
  output logic       pix_pop,
  input  rgb565_t    pix_data,
  input  logic       pix_empty,
  output logic       hsync,
  output logic       vsync,
  output logic [4:0] red,
  output logic [5:0] green,
  output logic [4:0] blue,
  output logic       underrun
);

  rgb565_t colour_q;
  // set by first vsync, pixel path is only aligned to the frame after that
  logic    armed;
  logic    show;

  assign show    = raster.visible && armed;
  // one pixel per visible cycle
  assign pix_pop = show && !pix_empty;

  assign red   = colour_q.red;
  assign green = colour_q.green;
  assign blue  = colour_q.blue;

  always_ff @(posedge clk_axi or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hsync    <= 1'b0;
      vsync    <= 1'b0;
      colour_q <= '0;
      armed    <= 1'b0;
      underrun <= 1'b0;
    end
    else
    begin
      // syncs follow colour by the same cycle
      hsync <= raster.hsync;
      vsync <= raster.vsync;
      if (raster.vsync)
        armed <= 1'b1;
      // black outside the window or when starved
      colour_q <= pix_pop ? pix_data : '0;
      // sticky until reset
      if (show && pix_empty)
        underrun <= 1'b1;
    end
  end

endmodule

// ==== rtl/pixel_unpack.sv ====
`timescale 1ns/1ps

module pixel_unpack
  import vga_pkg::*;
#(
  parameter int PIX_DEPTH = 8
)
(
  input  logic      clk_axi,
  input  logic      rst_n,
  input  logic      clear,
  output logic      word_pop,
  input  mem_word_t word_data,
  input  logic      word_empty,
  input  logic      pix_pop,
  output rgb565_t   pix_data,
  output logic      pix_empty
);

  mem_word_t word_q;
  logic      word_valid;
  // 0 low half next, 1 high half next
  logic      half;
  logic      pix_full;
  logic      pix_push;
  rgb565_t   pix_half;

  // stall on full pixel fifo
  assign pix_push = word_valid && !pix_full && !clear;
  assign pix_half = half ? rgb565_t'(word_q[31:16]) : rgb565_t'(word_q[15:0]);
  // refill when idle or while sending the high half
  assign word_pop = !clear && !word_empty && (!word_valid || (half && pix_push));

  always_ff @(posedge clk_axi)
  begin
    if (word_pop)
      word_q <= word_data;
  end

  always_ff @(posedge clk_axi or negedge rst_n)
  begin
    if (!rst_n)
    begin
      word_valid <= 1'b0;
      half       <= 1'b0;
    end
    else if (clear)
    begin
      word_valid <= 1'b0;
      half       <= 1'b0;
    end
    else if (word_pop)
    begin
      word_valid <= 1'b1;
      half       <= 1'b0;
    end
    else if (pix_push)
    begin
      // high half gone and nothing new to load
      if (half)
        word_valid <= 1'b0;
      half <= !half;
    end
  end

  // pixel fifo
  sync_fifo #(
    .payload_t (rgb565_t),
    .DEPTH     (PIX_DEPTH)
  ) u_pix_fifo (
    .clk_axi   (clk_axi),
    .rst_n     (rst_n),
    .clear     (clear),
    .push      (pix_push),
    .push_data (pix_half),
    .pop       (pix_pop),
    .pop_data  (pix_data),
    .empty     (pix_empty),
    .full      (pix_full),
    .level     ()
  );

endmodule

// ==== video_fetch/video_fetch.sv ====
`timescale 1ns/1ps

module video_fetch
  import vga_pkg::*;
#(
  parameter logic [31:0] FRAME_BASE  = FRAME_BASE_DEFAULT,
  parameter int          BURST_WORDS = BURST_WORDS_DEFAULT,
  parameter int          WORD_DEPTH  = 32
)
(
  input  logic      clk_axi,
  input  logic      rst_n,
  input  logic      clear,
  output mem_req_t  mem_req,
  input  mem_rsp_t  mem_rsp,
  input  logic      word_pop,
  output mem_word_t word_data,
  output logic      word_empty
);

  localparam int          LW          = $clog2(WORD_DEPTH + 1);
  localparam logic [31:0] BURST_BYTES = 32'(BURST_WORDS * 4);

  logic [31:0]   next_addr;
  // words of the current burst not yet returned
  logic [11:0]   owed;
  // drop the rest of a burst that overlapped a restart
  logic          discard;
  logic [LW-1:0] word_level;
  logic          word_push;
  logic          room;
  logic          issue;

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  // stored words plus owed words plus a new burst must fit
  assign room  = (32'(word_level) + 32'(owed) + 32'(BURST_WORDS)) <= 32'(WORD_DEPTH);
  // one burst in flight at most
  assign issue = !clear && (owed == '0) && room;

  always_ff @(posedge clk_axi or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mem_req   <= '0;
      owed      <= '0;
      next_addr <= FRAME_BASE;
      discard   <= 1'b0;
    end
    else
    begin
      mem_req.req <= issue;
      if (issue)
      begin
        mem_req.addr   <= next_addr;
        mem_req.length <= 12'(BURST_WORDS);
        owed           <= 12'(BURST_WORDS);
      end
      else if (mem_rsp.rd_valid && (owed != '0))
        owed <= owed - 1'b1;

      // restart rewinds to top of frame
      if (clear)
        next_addr <= FRAME_BASE;
      else if (issue)
        next_addr <= next_addr + BURST_BYTES;

      // burst outstanding across clear, finish it but throw data away
      if (clear && (owed != '0))
        discard <= 1'b1;
      else if (owed == '0)
        discard <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  assign word_push = mem_rsp.rd_valid && (owed != '0) && !discard && !clear;

  // word fifo
  sync_fifo #(
    .payload_t (mem_word_t),
    .DEPTH     (WORD_DEPTH)
  ) u_word_fifo (
    .clk_axi   (clk_axi),
    .rst_n     (rst_n),
    .clear     (clear),
    .push      (word_push),
    .push_data (mem_rsp.rd_data),
    .pop       (word_pop),
    .pop_data  (word_data),
    .empty     (word_empty),
    .full      (),
    .level     (word_level)
  );

endmodule

// ==== video_timing/frame_restart.sv ====
`timescale 1ns/1ps

module frame_restart
  import vga_pkg::*;
#(
  parameter int RESTART_CYCLES = RESTART_CYCLES_DEFAULT
)
(
  input  logic clk_axi,
  input  logic rst_n,
  input  logic vsync,
  output logic clear
);

  localparam int CW = $clog2(RESTART_CYCLES + 1);

  // waiting for vsync, holding clear, waiting for vsync to drop
  typedef enum logic [1:0] {
    ST_WAIT,
    ST_RESTART,
    ST_ENDED
  } state_t;

  state_t        state;
  logic          vsync_q;
  logic [CW-1:0] hold_cnt;

  always_ff @(posedge clk_axi or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_WAIT;
      vsync_q  <= 1'b0;
      hold_cnt <= '0;
    end
    else
    begin
      vsync_q <= vsync;
      case (state)
        ST_WAIT:
          // rising edge of vsync
          if (vsync && !vsync_q)
          begin
            state    <= ST_RESTART;
            hold_cnt <= CW'(RESTART_CYCLES - 1);
          end
        ST_RESTART:
          if (hold_cnt == '0)
            state <= ST_ENDED;
          else
            hold_cnt <= hold_cnt - 1'b1;
        ST_ENDED:
          if (!vsync)
            state <= ST_WAIT;
        default:
          state <= ST_WAIT;
      endcase
    end
  end

  assign clear = (state == ST_RESTART);

endmodule

// ==== video_timing/video_timing.sv ====
`timescale 1ns/1ps

module video_timing
  import vga_pkg::*;
#(
  parameter timing_cfg_t TIMING = default_timing
)
(
  input  logic    clk_axi,
  input  logic    rst_n,
  output raster_t raster
);

  ////////////////////////////////////////////////////////////
  // raster geometry
  ////////////////////////////////////////////////////////////

  localparam logic [POS_W-1:0] H_ACTIVE = TIMING.h_active;
  localparam logic [POS_W-1:0] V_ACTIVE = TIMING.v_active;

  // sync window, after active and front porch
  localparam logic [POS_W-1:0] H_SYNC_START = TIMING.h_active + TIMING.h_front;
  localparam logic [POS_W-1:0] H_SYNC_END   = H_SYNC_START + TIMING.h_sync;
  localparam logic [POS_W-1:0] V_SYNC_START = TIMING.v_active + TIMING.v_front;
  localparam logic [POS_W-1:0] V_SYNC_END   = V_SYNC_START + TIMING.v_sync;

  // full period per axis
  localparam logic [POS_W-1:0] H_TOTAL = H_SYNC_END + TIMING.h_back;
  localparam logic [POS_W-1:0] V_TOTAL = V_SYNC_END + TIMING.v_back;

  logic [POS_W-1:0] h_next;
  logic [POS_W-1:0] v_next;

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  // next position, line advances at end of each row
  always_comb
  begin
    h_next = raster.h_pos + 1'b1;
    v_next = raster.v_pos;
    if (raster.h_pos == H_TOTAL - 1'b1)
    begin
      h_next = '0;
      if (raster.v_pos == V_TOTAL - 1'b1)
        v_next = '0;
      else
        v_next = raster.v_pos + 1'b1;
    end
  end

  // flags decoded from next position so every field moves on one edge
  always_ff @(posedge clk_axi or negedge rst_n)
  begin
    if (!rst_n)
    begin
      raster <= '{hsync: 1'b0, vsync: 1'b0, visible: 1'b1, h_pos: '0, v_pos: '0};
    end
    else
    begin
      raster.h_pos   <= h_next;
      raster.v_pos   <= v_next;
      // active high syncs
      raster.hsync   <= (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
      raster.vsync   <= (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);
      raster.visible <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
    end
  end

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
  import vga_pkg::*;
#(
  parameter type payload_t = mem_word_t,
  parameter int  DEPTH     = 8
)
(
  input  logic                       clk_axi,
  input  logic                       rst_n,
  input  logic                       clear,
  input  logic                       push,
  input  payload_t                   push_data,
  input  logic                       pop,
  output payload_t                   pop_data,
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] level
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [LW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // overflow and underflow requests are dropped
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == LW'(DEPTH));
  assign level    = count;
  // head of queue is always on the output
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk_axi)
  begin
    if (do_push && !clear)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk_axi or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      // flush in a single cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== common/vga_pkg.sv ====
package vga_pkg;

  ////////////////////////////////////////////////////////////
  // widths and defaults
  ////////////////////////////////////////////////////////////

  // raster position width, both axes
  localparam int POS_W = 11;

  // frame buffer start in memory
  localparam logic [31:0] FRAME_BASE_DEFAULT = 32'h1fb0_0000;
  // words per memory burst
  localparam int BURST_WORDS_DEFAULT = 16;
  // cycles the pixel path is held in clear after vsync
  localparam int RESTART_CYCLES_DEFAULT = 400;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // one pixel, memory layout and pin layout
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // pixel 0 in [15:0], pixel 1 in [31:16]
  typedef logic [31:0] mem_word_t;

  // registered raster state
  typedef struct packed {
    logic             hsync;
    logic             vsync;
    logic             visible;
    logic [POS_W-1:0] h_pos;
    logic [POS_W-1:0] v_pos;
  } raster_t;

  // burst request, req is a single cycle pulse
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic [11:0] length;
  } mem_req_t;

  // one read strobe per word
  typedef struct packed {
    logic      rd_valid;
    mem_word_t rd_data;
  } mem_rsp_t;

  // porch and sync widths for both axes
  typedef struct packed {
    logic [POS_W-1:0] h_active;
    logic [POS_W-1:0] h_front;
    logic [POS_W-1:0] h_sync;
    logic [POS_W-1:0] h_back;
    logic [POS_W-1:0] v_active;
    logic [POS_W-1:0] v_front;
    logic [POS_W-1:0] v_sync;
    logic [POS_W-1:0] v_back;
  } timing_cfg_t;

  // 1360x768 panel timing
  localparam timing_cfg_t default_timing = '{
    h_active: 11'd1360, h_front: 11'd48, h_sync: 11'd112, h_back: 11'd248,
    v_active: 11'd768,  v_front: 11'd1,  v_sync: 11'd3,   v_back: 11'd38
  };

  // tiny raster, 24 by 8 total
  localparam timing_cfg_t sim_timing = '{
    h_active: 11'd16, h_front: 11'd2, h_sync: 11'd3, h_back: 11'd3,
    v_active: 11'd4,  v_front: 11'd1, v_sync: 11'd1, v_back: 11'd2
  };

endpackage
